// ==== hdl/memtest_pkg.sv ====
// Shared widths, address limits, LFSR seeds and types for the DDR local-port
// memory test driver. Imported by every module that needs them.
`default_nettype none

package memtest_pkg;

  // ------------------------------------------------------------------------
  // widths and limits
  // ------------------------------------------------------------------------
  localparam int data_w = 32;
  localparam int lanes  = 4;
  localparam int row_w  = 13;
  localparam int col_w  = 9;
  localparam int bank_w = 2;

  // bounds of the sequential pass
  localparam logic [row_w-1:0]  max_row  = 13'd3;
  localparam logic [col_w-1:0]  max_col  = 9'd16;
  localparam logic [bank_w-1:0] max_bank = 2'd3;
  localparam logic [col_w-1:0]  col_step = 9'd2;

  // a pin-walking pass ends on this row
  localparam logic [row_w-1:0] row_pin_all = {row_w{1'b1}};

  // one seed per byte lane, lane 0 in the low slot
  localparam logic [lanes-1:0][7:0] lane_seed = {8'd31, 8'd21, 8'd11, 8'd1};

  // tests run after reset
  localparam bit test_seq_on  = 1'b1;
  localparam bit test_dm_on   = 1'b1;
  localparam bit test_addr_on = 1'b1;

  // ------------------------------------------------------------------------
  // types
  // ------------------------------------------------------------------------
  typedef enum logic [3:0] {
    idle,
    start,
    dm_clear,
    write_drain,
    reload,
    write,
    write_done,
    read,
    read_drain,
    done
  } seq_state_t;

  typedef struct packed {
    logic seq_addr;
    logic dm_pin;
    logic addr_pin;
  } test_mode_t;

  typedef struct packed {
    logic [bank_w-1:0] bank;
    logic [row_w-1:0]  row;
    logic [col_w-1:0]  col;
  } mem_addr_t;

  // everything the driver presents to the controller
  typedef struct packed {
    logic              write_req;
    logic              read_req;
    logic              burstbegin;
    mem_addr_t         addr;
    logic [lanes-1:0]  be;
    logic [data_w-1:0] wdata;
  } local_cmd_t;

  typedef struct packed {
    logic              ready;
    logic              rdata_valid;
    logic [data_w-1:0] rdata;
  } local_rsp_t;

  // complete in bit 7 and the mode flags in bits 3, 2 and 0
  typedef struct packed {
    logic       complete;
    logic [2:0] rsvd_hi;
    logic       addr_pin;
    logic       dm_pin;
    logic       rsvd_lo;
    logic       seq_addr;
  } status_t;

endpackage

`default_nettype wire

// ==== hdl/lfsr8.sv ====
// One byte lane of the test pattern generator. An 8-bit Fibonacci LFSR that
// starts from its seed, can be reloaded and holds while paused.
`timescale 1ns/1ps
`default_nettype none

module lfsr8 #(
  parameter logic [7:0] seed = 8'd1
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       load,
  input  logic [7:0] ldata,
  input  logic       pause,
  output logic [7:0] data
);

  logic feedback;

  // taps 8, 6, 5, 4
  assign feedback = data[7] ^ data[5] ^ data[4] ^ data[3];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      data <= seed;
    else if (load)
      data <= ldata;
    else if (!pause)
      data <= {data[6:0], feedback};
  end

endmodule

`default_nettype wire

// ==== hdl/address_gen.sv ====
// Address counters for the memory tests. Steps on each accepted access:
// a bounded column/row/bank sweep, or a one-hot walk over the address pins.
`timescale 1ns/1ps
`default_nettype none

module address_gen
  import memtest_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  test_mode_t mode,
  input  logic       accept,
  input  logic       addr_reset,
  output mem_addr_t  addr,
  output logic       at_last
);

  logic pin_mode;

  // dm and address-pin tests share the walking pattern
  assign pin_mode = mode.dm_pin | mode.addr_pin;

  always_comb
  begin
    if (pin_mode)
      at_last = (addr.row == row_pin_all);
    else
      at_last = mode.seq_addr && (addr.col == max_col) && (addr.row == max_row) &&
                (addr.bank == max_bank);
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      addr <= '0;
    else if (addr_reset)
      addr <= '0;
    else if (accept && pin_mode)
    begin
      addr.bank <= addr.bank + 1'b1;
      if (addr.row == '0)
      begin
        // first step out of the all-zero address
        addr.row <= 13'd1;
        addr.col <= 9'd2;
      end
      else if (addr.row == {1'b1, {(row_w - 1){1'b0}}})
      begin
        // one-hot done, switch to the walking zero
        addr.row <= {{(row_w - 1){1'b1}}, 1'b0};
        addr.col <= {{(col_w - 2){1'b1}}, 2'b00};
      end
      else if (addr.row == {1'b0, {(row_w - 1){1'b1}}})
      begin
        addr.row <= row_pin_all;
        addr.col <= {{(col_w - 1){1'b1}}, 1'b0};
      end
      else
      begin
        addr.row <= {addr.row[row_w-2:0], addr.row[row_w-1]};
        // col bit 0 stays put, bits 8 to 1 rotate
        addr.col <= {addr.col[col_w-2:1], addr.col[col_w-1], addr.col[0]};
      end
    end
    else if (accept && mode.seq_addr)
    begin
      if (addr.col >= max_col)
      begin
        addr.col <= '0;
        if (addr.row == max_row)
        begin
          addr.row <= '0;
          if (addr.bank == max_bank)
            addr.bank <= '0;
          else
            addr.bank <= addr.bank + 1'b1;
        end
        else
          addr.row <= addr.row + 1'b1;
      end
      else
        addr.col <= addr.col + col_step;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/pattern_gen.sv ====
// Write and expected-read data source: four byte-lane LFSRs with a reload
// register, zero-data gating for the dm clear pass and the byte-enable rotator.
`timescale 1ns/1ps
`default_nettype none

module pattern_gen
  import memtest_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  test_mode_t        mode,
  input  logic              wr_accept,
  input  logic              rdata_valid,
  input  logic              dgen_load,
  input  logic              capture_seed,
  input  logic              be_reset,
  input  logic              zero_data,
  output logic [data_w-1:0] data,
  output logic [lanes-1:0]  be
);

  logic [data_w-1:0] lfsr_data;
  logic [data_w-1:0] reload_data;
  logic              advance;
  logic              pause;

  // step on every real write and on every returned read beat
  assign advance = (wr_accept & ~zero_data) | rdata_valid;
  assign pause   = ~advance;
  assign data    = zero_data ? '0 : lfsr_data;

  for (genvar i = 0; i < lanes; i++)
  begin : g_lane
    lfsr8 #(
      .seed(lane_seed[i])
    ) u_lfsr (
      .clk    (clk),
      .reset_n(reset_n),
      .load   (dgen_load),
      .ldata  (reload_data[8*i +: 8]),
      .pause  (pause),
      .data   (lfsr_data[8*i +: 8])
    );
  end

  // start value of the current test, replayed for the read pass
  always_ff @(posedge clk)
  begin
    if (capture_seed)
      reload_data <= lfsr_data;
  end

  // ------------------------------------------------------------------------
  // byte enables
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      be <= '1;
    else if (be_reset)
      be <= {{(lanes - 1){1'b0}}, 1'b1};
    else if (mode.dm_pin && advance)
      be <= {be[lanes-2:0], be[lanes-1]};
    else if (!mode.dm_pin || zero_data)
      be <= '1;
  end

endmodule

`default_nettype wire

// ==== hdl/read_checker.sv ====
// Compares read data against the regenerated pattern, masked per byte lane by
// the byte enable, and keeps a pass flag that falls on the first mismatch.
`timescale 1ns/1ps
`default_nettype none

module read_checker
  import memtest_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic              rdata_valid,
  input  logic [data_w-1:0] rdata,
  input  logic [data_w-1:0] exp_data,
  input  logic [lanes-1:0]  be,
  output logic [lanes-1:0]  pnf_per_byte,
  output logic              pnf_persist
);

  logic [lanes-1:0] lane_ok;
  logic [lanes-1:0] lane_ok_q;
  logic [lanes-1:0] lane_latched;
  logic             valid_d1;
  logic             seen;
  logic             seen_d1;
  logic             seen_d2;
  logic             persist_int;

  // disabled lanes must read back as zero
  always_comb
  begin
    for (int i = 0; i < lanes; i++)
      lane_ok[i] = ((exp_data[8*i +: 8] & {8{be[i]}}) == rdata[8*i +: 8]);
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      lane_ok_q    <= '1;
      lane_latched <= '1;
      pnf_per_byte <= '1;
      valid_d1     <= 1'b0;
      seen         <= 1'b0;
      seen_d1      <= 1'b0;
      seen_d2      <= 1'b0;
      persist_int  <= 1'b0;
      pnf_persist  <= 1'b0;
    end
    else
    begin
      lane_ok_q <= lane_ok;
      valid_d1  <= rdata_valid;
      if (rdata_valid)
        seen <= 1'b1;
      seen_d1 <= seen;
      seen_d2 <= seen_d1;
      // hold the last real compare between beats
      if (valid_d1)
        lane_latched <= lane_ok_q;
      pnf_per_byte <= lane_latched;
      persist_int  <= (&lane_latched) & seen_d1 & (seen_d2 ? persist_int : 1'b1);
      pnf_persist  <= persist_int;
    end
  end

  a_rdata_known: assert property (@(posedge clk) disable iff (!reset_n)
    rdata_valid |-> !$isunknown(rdata));

endmodule

`default_nettype wire

// ==== hdl/test_sequencer.sv ====
// Control FSM of the memory test driver. Runs each enabled test as a write
// pass and a read pass, issues local-port requests and tracks reads in flight.
`timescale 1ns/1ps
`default_nettype none

module test_sequencer
  import memtest_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  local_rsp_t rsp,
  input  logic       at_last,
  output logic       req_write,
  output logic       req_read,
  output logic       burstbegin,
  output test_mode_t mode,
  output logic       addr_reset,
  output logic       dgen_load,
  output logic       be_reset,
  output logic       zero_data,
  output logic       capture_seed,
  output logic       complete
);

  seq_state_t state;
  logic       pend_seq;
  logic       pend_dm;
  logic       pend_addr;
  logic       any_pending;
  logic       rd_accept;
  logic [7:0] outstanding;

  assign any_pending = pend_seq | pend_dm | pend_addr;
  assign rd_accept   = req_read & rsp.ready;

  // reads accepted but not yet returned
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      outstanding <= '0;
    else if (rd_accept && !rsp.rdata_valid)
      outstanding <= outstanding + 8'd1;
    else if (!rd_accept && rsp.rdata_valid)
      outstanding <= outstanding - 8'd1;
  end

  // ------------------------------------------------------------------------
  // test FSM
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state        <= idle;
      req_write    <= 1'b0;
      req_read     <= 1'b0;
      burstbegin   <= 1'b0;
      mode         <= '0;
      addr_reset   <= 1'b0;
      dgen_load    <= 1'b0;
      be_reset     <= 1'b0;
      zero_data    <= 1'b0;
      capture_seed <= 1'b0;
      complete     <= 1'b0;
      pend_seq     <= 1'b0;
      pend_dm      <= 1'b0;
      pend_addr    <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
        begin
          pend_seq  <= test_seq_on;
          pend_dm   <= test_dm_on;
          pend_addr <= test_addr_on;
          complete  <= 1'b0;
          state     <= start;
        end
        start:
        begin
          // pick the next pending test and present its first write
          addr_reset   <= 1'b0;
          req_write    <= any_pending;
          burstbegin   <= any_pending;
          capture_seed <= any_pending;
          if (pend_seq)
          begin
            mode.seq_addr <= 1'b1;
            state         <= write;
          end
          else if (pend_dm)
          begin
            mode.dm_pin <= 1'b1;
            zero_data   <= 1'b1;
            state       <= dm_clear;
          end
          else if (pend_addr)
          begin
            mode.addr_pin <= 1'b1;
            state         <= write;
          end
          else
            state <= done;
        end
        dm_clear, write:
        begin
          capture_seed <= 1'b0;
          if (!rsp.ready)
            burstbegin <= 1'b0;
          else if (at_last)
          begin
            req_write  <= 1'b0;
            burstbegin <= 1'b0;
            if (state == write)
            begin
              addr_reset <= 1'b1;
              state      <= write_done;
            end
            else
              state <= write_drain;
          end
          else
            burstbegin <= 1'b1;
        end
        write_drain:
        begin
          be_reset   <= 1'b1;
          addr_reset <= 1'b1;
          dgen_load  <= 1'b1;
          state      <= reload;
        end
        reload:
        begin
          // clear pass over, rewrite the same addresses with real data
          addr_reset <= 1'b0;
          dgen_load  <= 1'b0;
          be_reset   <= 1'b0;
          zero_data  <= 1'b0;
          req_write  <= 1'b1;
          burstbegin <= 1'b1;
          state      <= write;
        end
        write_done:
        begin
          addr_reset <= 1'b0;
          dgen_load  <= 1'b1;
          be_reset   <= 1'b1;
          req_read   <= 1'b1;
          burstbegin <= 1'b1;
          state      <= read;
        end
        read:
        begin
          dgen_load <= 1'b0;
          be_reset  <= 1'b0;
          if (!rsp.ready)
            burstbegin <= 1'b0;
          else if (at_last)
          begin
            req_read   <= 1'b0;
            burstbegin <= 1'b0;
            state      <= read_drain;
          end
          else
            burstbegin <= 1'b1;
        end
        read_drain:
        begin
          if (outstanding == 8'd0)
          begin
            addr_reset <= 1'b1;
            mode       <= '0;
            if (mode.seq_addr)
              pend_seq <= 1'b0;
            else if (mode.dm_pin)
              pend_dm <= 1'b0;
            else
              pend_addr <= 1'b0;
            state <= start;
          end
        end
        done:
          complete <= 1'b1;
        default:
          state <= idle;
      endcase
    end
  end

  a_req_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
    !(req_read && req_write));

  // a returned beat must belong to an accepted read
  a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
    rsp.rdata_valid |-> (outstanding != 8'd0));

endmodule

`default_nettype wire

// ==== hdl/memtest_driver.sv ====
// Top level of the DDR SDRAM local-port test driver. Connect cmd and rsp to
// the controller; status.complete rises once all tests have run.
`timescale 1ns/1ps
`default_nettype none

module memtest_driver
  import memtest_pkg::*;
(
  input  logic             clk,
  input  logic             reset_n,
  output local_cmd_t       cmd,
  input  local_rsp_t       rsp,
  output logic [lanes-1:0] pnf_per_byte,
  output logic             pnf_persist,
  output status_t          status
);

  test_mode_t        mode;
  mem_addr_t         addr;
  logic              req_write;
  logic              req_read;
  logic              burstbegin;
  logic              at_last;
  logic              addr_reset;
  logic              dgen_load;
  logic              be_reset;
  logic              zero_data;
  logic              capture_seed;
  logic              complete;
  logic              accept;
  logic              wr_accept;
  logic [data_w-1:0] data;
  logic [lanes-1:0]  be;

  assign accept    = rsp.ready & (req_write | req_read);
  assign wr_accept = rsp.ready & req_write;

  test_sequencer u_sequencer (
    .clk         (clk),
    .reset_n     (reset_n),
    .rsp         (rsp),
    .at_last     (at_last),
    .req_write   (req_write),
    .req_read    (req_read),
    .burstbegin  (burstbegin),
    .mode        (mode),
    .addr_reset  (addr_reset),
    .dgen_load   (dgen_load),
    .be_reset    (be_reset),
    .zero_data   (zero_data),
    .capture_seed(capture_seed),
    .complete    (complete)
  );

  address_gen u_address_gen (
    .clk       (clk),
    .reset_n   (reset_n),
    .mode      (mode),
    .accept    (accept),
    .addr_reset(addr_reset),
    .addr      (addr),
    .at_last   (at_last)
  );

  pattern_gen u_pattern_gen (
    .clk         (clk),
    .reset_n     (reset_n),
    .mode        (mode),
    .wr_accept   (wr_accept),
    .rdata_valid (rsp.rdata_valid),
    .dgen_load   (dgen_load),
    .capture_seed(capture_seed),
    .be_reset    (be_reset),
    .zero_data   (zero_data),
    .data        (data),
    .be          (be)
  );

  read_checker u_read_checker (
    .clk         (clk),
    .reset_n     (reset_n),
    .rdata_valid (rsp.rdata_valid),
    .rdata       (rsp.rdata),
    .exp_data    (data),
    .be          (be),
    .pnf_per_byte(pnf_per_byte),
    .pnf_persist (pnf_persist)
  );

  // ------------------------------------------------------------------------
  // outward faces
  // ------------------------------------------------------------------------
  assign cmd = '{write_req : req_write,
                 read_req  : req_read,
                 burstbegin: burstbegin,
                 addr      : addr,
                 be        : be,
                 wdata     : data};

  assign status = '{complete: complete,
                    rsvd_hi : 3'b000,
                    addr_pin: mode.addr_pin,
                    dm_pin  : mode.dm_pin,
                    rsvd_lo : 1'b0,
                    seq_addr: mode.seq_addr};

endmodule

`default_nettype wire

// ==== verif/sdram_local_model.sv ====
// Behavioral local-port memory for the test driver testbench. Random ready
// stalls, fixed read latency and a single-beat byte-lane fault injector.
`timescale 1ns/1ps
`default_nettype none

module sdram_local_model
  import memtest_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  local_cmd_t cmd,
  output local_rsp_t rsp,
  input  int         stall_pct,
  input  logic       fault_on,
  input  logic [1:0] fault_lane,
  input  int         fault_beat
);

  // read beat shows up 4 edges after the accepting edge
  localparam int pipe_len = 3;

  logic [data_w-1:0]   mem [logic [23:0]];
  logic [pipe_len-1:0] vld_pipe;
  logic [data_w-1:0]   dat_pipe [pipe_len];
  logic [data_w-1:0]   word;
  int                  beat_count;
  integer              seed = 86;

  always @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rsp        <= '0;
      vld_pipe   <= '0;
      beat_count <= 0;
    end
    else
    begin
      rsp.ready <= ($unsigned($random(seed)) % 100) >= stall_pct;
      // untouched locations read back a pattern of their full address
      word = mem.exists(cmd.addr) ? mem[cmd.addr] : {cmd.addr[7:0], cmd.addr};
      if (rsp.ready && cmd.write_req)
      begin
        for (int i = 0; i < lanes; i++)
          if (cmd.be[i])
            word[8*i +: 8] = cmd.wdata[8*i +: 8];
        mem[cmd.addr] = word;
      end
      vld_pipe    <= {vld_pipe[pipe_len-2:0], rsp.ready & cmd.read_req};
      dat_pipe[0] <= word;
      for (int i = 1; i < pipe_len; i++)
        dat_pipe[i] <= dat_pipe[i-1];

      rsp.rdata_valid <= vld_pipe[pipe_len-1];
      rsp.rdata       <= dat_pipe[pipe_len-1];
      if (vld_pipe[pipe_len-1])
      begin
        beat_count <= beat_count + 1;
        // flip one whole lane of the chosen beat
        if (fault_on && beat_count == fault_beat)
          rsp.rdata <= dat_pipe[pipe_len-1] ^ (32'hff << (8 * fault_lane));
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_memtest_driver.sv ====
// Self-checking testbench for the memory test driver. Runs a table of stall
// and fault scenarios against the local-port model and checks every access.
`timescale 1ns/1ps
`default_nettype none

module tb_memtest_driver;
  import memtest_pkg::*;

  typedef struct packed {
    int               stall_pct;
    logic             fault_on;
    logic [1:0]       fault_lane;
    int               fault_beat;
    logic [lanes-1:0] exp_pnf;
    logic             exp_persist;
  } scenario_t;

  localparam int n_rows = 4;
  // beats 0..143 seq, 144..171 dm, 172..199 addr
  localparam scenario_t scenarios [n_rows] = '{
    '{0,  1'b0, 2'd0, 0,   4'b1111, 1'b1},
    '{40, 1'b0, 2'd0, 0,   4'b1111, 1'b1},
    '{20, 1'b1, 2'd1, 150, 4'b1111, 1'b0},
    '{0,  1'b1, 2'd2, 199, 4'b1011, 1'b0}
  };

  localparam int seq_len = (int'(max_col) / int'(col_step) + 1) * (int'(max_row) + 1) *
                           (int'(max_bank) + 1);
  // one-hot walk, walking zero, plus the all-zero and all-ones rows
  localparam int pin_len = 2 * row_w + 2;
  localparam mem_addr_t seq_last = '{bank: max_bank, row: max_row, col: max_col};
  localparam mem_addr_t pin_last = '{bank: 2'd3, row: row_pin_all, col: 9'h1fe};

  logic             clk = 1'b0;
  logic             reset_n = 1'b0;
  local_cmd_t       cmd;
  local_rsp_t       rsp;
  logic [lanes-1:0] pnf_per_byte;
  logic             pnf_persist;
  status_t          status;
  int               stall_pct = 0;
  logic             fault_on = 1'b0;
  logic [1:0]       fault_lane = 2'd0;
  int               fault_beat = 0;
  int               errors = 0;
  int               checks = 0;

  // bus monitor state
  logic             prev_req;
  logic             prev_acc;
  local_cmd_t       prev_cmd;
  mem_addr_t        exp_addr;
  mem_addr_t        last_addr;
  logic             pass_seq;
  int               pass_count;
  int               dm_wr_pass;
  logic [lanes-1:0] exp_be;
  status_t          mode_log [$];

  always #50 clk = ~clk;

  memtest_driver UUT (
    .clk         (clk),
    .reset_n     (reset_n),
    .cmd         (cmd),
    .rsp         (rsp),
    .pnf_per_byte(pnf_per_byte),
    .pnf_persist (pnf_persist),
    .status      (status)
  );

  sdram_local_model u_model (
    .clk       (clk),
    .reset_n   (reset_n),
    .cmd       (cmd),
    .rsp       (rsp),
    .stall_pct (stall_pct),
    .fault_on  (fault_on),
    .fault_lane(fault_lane),
    .fault_beat(fault_beat)
  );

  // --------------------------------------------------------------------------
  // expected address steps
  // --------------------------------------------------------------------------
  function automatic mem_addr_t next_seq_addr(input mem_addr_t a);
    mem_addr_t n;
    n = a;
    if (a.col == max_col)
    begin
      n.col = '0;
      n.row = (a.row == max_row) ? '0 : a.row + 1'b1;
      if (a.row == max_row)
        n.bank = a.bank + 1'b1;
    end
    else
      n.col = a.col + col_step;
    return n;
  endfunction

  function automatic mem_addr_t next_pin_addr(input mem_addr_t a);
    mem_addr_t n;
    n.bank = a.bank + 1'b1;
    if (a.row == 13'h0000)
    begin
      n.row = 13'h0001;
      n.col = 9'h002;
    end
    else if (a.row == 13'h1000)
    begin
      n.row = 13'h1ffe;
      n.col = 9'h1fc;
    end
    else if (a.row == 13'h0fff)
    begin
      n.row = 13'h1fff;
      n.col = 9'h1fe;
    end
    else
    begin
      n.row = {a.row[11:0], a.row[12]};
      n.col = {a.col[7:1], a.col[8], a.col[0]};
    end
    return n;
  endfunction

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic report_mismatch(input string msg);
    errors++;
    $display("MISMATCH at %0t ns: %s", $time, msg);
  endtask

  task automatic check_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
    checks++;
    if (got !== exp)
      report_mismatch($sformatf("%s: got bank %0d row %h col %h, expected bank %0d row %h col %h",
                                what, got.bank, got.row, got.col, exp.bank, exp.row, exp.col));
  endtask

  task automatic check_status(input status_t got, input status_t exp, input string what);
    checks++;
    if (got !== exp)
      report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
  endtask

  task automatic check_pnf(input logic [lanes-1:0] got_lanes, input logic got_persist,
                           input logic [lanes-1:0] exp_lanes, input logic exp_persist);
    checks++;
    if (got_lanes !== exp_lanes || got_persist !== exp_persist)
      report_mismatch($sformatf("pnf: got per byte %b persist %b, expected %b and %b",
                                got_lanes, got_persist, exp_lanes, exp_persist));
  endtask

  task automatic check_be(input logic [lanes-1:0] got, input logic [lanes-1:0] exp,
                          input string what);
    checks++;
    if (got !== exp)
      report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp)
      report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_cmd(input local_cmd_t got, input local_cmd_t exp, input string what);
    checks++;
    if (got !== exp)
      report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  // --------------------------------------------------------------------------
  // bus monitor
  // --------------------------------------------------------------------------
  always @(posedge clk)
  begin : bus_monitor
    logic       req;
    logic       acc;
    local_cmd_t exp_cmd;
    req = cmd.write_req | cmd.read_req;
    acc = req & rsp.ready;
    if (!reset_n)
    begin
      prev_req   = 1'b0;
      prev_acc   = 1'b0;
      dm_wr_pass = 0;
      mode_log.delete();
    end
    else
    begin
      if (req)
      begin
        // a stalled request keeps its address, and write data too
        exp_cmd = (prev_req && !prev_acc) ? prev_cmd : cmd;
        if (cmd.read_req)
        begin
          exp_cmd.be    = cmd.be;
          exp_cmd.wdata = cmd.wdata;
        end
        exp_cmd.burstbegin = !prev_req || prev_acc;
        check_cmd(cmd, exp_cmd, "request face");
      end
      if (req && !prev_req)
      begin
        exp_addr   = '0;
        pass_count = 0;
        pass_seq   = status.seq_addr;
        exp_be     = {{(lanes - 1){1'b0}}, 1'b1};
        if (status.dm_pin && cmd.write_req)
          dm_wr_pass++;
      end
      if (acc)
      begin
        check_addr(cmd.addr, exp_addr, "access address");
        exp_addr  = pass_seq ? next_seq_addr(exp_addr) : next_pin_addr(exp_addr);
        last_addr = cmd.addr;
        pass_count++;
        if (status.dm_pin && cmd.write_req && dm_wr_pass == 1)
          check_be(cmd.be, '1, "dm clear byte enable");
        else if (status.dm_pin && cmd.write_req)
        begin
          check_be(cmd.be, exp_be, "dm write byte enable");
          exp_be = {exp_be[lanes-2:0], exp_be[lanes-1]};
        end
        else if (cmd.write_req)
          check_be(cmd.be, '1, "write byte enable");
        if (mode_log.size() == 0 || mode_log[$] != status)
          mode_log.push_back(status);
      end
      if (!req && prev_req)
      begin
        check_count(pass_count, pass_seq ? seq_len : pin_len, "accesses in pass");
        check_addr(last_addr, pass_seq ? seq_last : pin_last, "last address of pass");
      end
      prev_req = req;
      prev_acc = acc;
      prev_cmd = cmd;
    end
  end

  // --------------------------------------------------------------------------
  // watchdog
  // --------------------------------------------------------------------------
  initial
  begin : watchdog
    real max_factor;
    real limit_ns;
    max_factor = 0.0;
    foreach (scenarios[i])
      if (real'(scenarios[i].stall_pct) / (100.0 - scenarios[i].stall_pct) > max_factor)
        max_factor = real'(scenarios[i].stall_pct) / (100.0 - scenarios[i].stall_pct);
    limit_ns = n_rows * 3 * 2 * 4100 * (1.0 + max_factor) * 100.0;
    #(limit_ns);
    $display("timeout: status.complete did not rise within %0.0f ns", limit_ns);
    $display("Test failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // scenario loop
  // --------------------------------------------------------------------------
  initial
  begin : scenario_loop
    int      row_errors;
    status_t exp_status;
    status_t exp_modes [3];
    exp_modes = '{'0, '0, '0};
    exp_modes[0].seq_addr = 1'b1;
    exp_modes[1].dm_pin   = 1'b1;
    exp_modes[2].addr_pin = 1'b1;
    exp_status = '0;
    exp_status.complete = 1'b1;

    for (int r = 0; r < n_rows; r++)
    begin
      @(posedge clk);
      reset_n    <= 1'b0;
      stall_pct  <= scenarios[r].stall_pct;
      fault_on   <= scenarios[r].fault_on;
      fault_lane <= scenarios[r].fault_lane;
      fault_beat <= scenarios[r].fault_beat;
      repeat (10) @(posedge clk);
      reset_n <= 1'b1;
      row_errors = errors;

      while (status.complete !== 1'b1)
        @(negedge clk);
      check_status(status, exp_status, "final status");
      check_pnf(pnf_per_byte, pnf_persist, scenarios[r].exp_pnf, scenarios[r].exp_persist);
      check_count(mode_log.size(), 3, "test modes seen");
      foreach (mode_log[i])
        if (i < 3)
          check_status(mode_log[i], exp_modes[i], "test mode order");

      row_errors = errors - row_errors;
      $display("row %0d: stall %0d%%, fault %s, %0d errors", r, scenarios[r].stall_pct,
               scenarios[r].fault_on ? $sformatf("lane %0d beat %0d", scenarios[r].fault_lane,
               scenarios[r].fault_beat) : "none", row_errors);
    end

    $display("%0d rows, %0d checks, %0d errors", n_rows, checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== memtest_driver.f ====
hdl/memtest_pkg.sv
hdl/lfsr8.sv
hdl/address_gen.sv
hdl/pattern_gen.sv
hdl/read_checker.sv
hdl/test_sequencer.sv
hdl/memtest_driver.sv
verif/sdram_local_model.sv
verif/tb_memtest_driver.sv
